/* src.f */
+incdir+src
+incdir+sim
src/gf_pkg.sv
src/gf64_power19.sv
src/sbox_core.sv
src/sbox_layer.sv
sim/tb_sbox_layer.sv

/* Makefile */
# Verilator flow for the S-box layer.

SIM := obj_dir/Vtb_sbox_layer

.PHONY: all run lint clean

all: run

$(SIM): src.f $(wildcard src/*) $(wildcard sim/*)
	verilator --binary --timing -j 0 -f src.f --top-module tb_sbox_layer

run: $(SIM)
	./$(SIM)

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module sbox_layer

clean:
	rm -rf obj_dir

/* sim/sbox_model.svh */
`ifndef SBOX_MODEL_SVH
`define SBOX_MODEL_SVH

// ****************************************
// GF(4) reference arithmetic
// ****************************************

// the nonzero elements 1, w and w+1 are w^0, w^1 and w^2.
function automatic int field_log(logic [1:0] a);
  return (a == 2'd1) ? 0 : (a == 2'd2) ? 1 : 2;
endfunction

function automatic logic [1:0] field_exp(int e);
  case (e % 3)
    0:       return 2'd1;
    1:       return 2'd2;
    default: return 2'd3;
  endcase
endfunction

function automatic logic [1:0] field_mul(logic [1:0] a, logic [1:0] b);
  if (a == 2'd0 || b == 2'd0) begin
    return 2'd0;
  end
  return field_exp(field_log(a) + field_log(b));
endfunction

function automatic logic [1:0] scale_if_nonzero(logic [1:0] a, logic [1:0] b);
  return (a != 2'd0) ? b : 2'd0; // a^3 is one for any nonzero a.
endfunction

// ****************************************
// S-box reference
// ****************************************

// row i of each matrix selects the input bits that feed output bit i.
localparam logic [5:0][5:0] fwd_rows = {6'h10, 6'h21, 6'h36, 6'h35, 6'h2e, 6'h27};
localparam logic [5:0][5:0] inv_rows = {6'h3c, 6'h05, 6'h36, 6'h06, 6'h10, 6'h25};

function automatic logic [5:0] apply_rows(logic [5:0][5:0] rows, logic [5:0] v);
  logic [5:0] r;
  for (int i = 0; i < 6; i++) begin
    r[i] = ^(rows[i] & v);
  end
  return r;
endfunction

function automatic gf_pkg::gf64_t tower_power19(gf_pkg::gf64_t a);
  logic [1:0] x0;
  logic [1:0] x1;
  logic [1:0] x2;
  logic [1:0] s0;
  logic [1:0] s1;
  logic [1:0] s2;
  gf_pkg::gf64_t r;
  x0 = a.digit[0];
  x1 = a.digit[1];
  x2 = a.digit[2];
  s0 = field_mul(x0, x0);
  s1 = field_mul(x1, x1);
  s2 = field_mul(x2, x2);
  r.digit[0] = x1 ^ x2 ^ scale_if_nonzero(x0, x1) ^ scale_if_nonzero(x2, x0)
             ^ scale_if_nonzero(x2, x1) ^ field_mul(s0, s1) ^ field_mul(s1, s2)
             ^ field_mul(s0, field_mul(x1, x2)) ^ field_mul(s1, field_mul(x0, x2));
  r.digit[1] = x0 ^ x2 ^ scale_if_nonzero(x0, x1) ^ scale_if_nonzero(x0, x2)
             ^ scale_if_nonzero(x1, x2) ^ field_mul(s0, s2) ^ field_mul(s1, s2)
             ^ field_mul(s1, field_mul(x0, x2)) ^ field_mul(s2, field_mul(x0, x1));
  r.digit[2] = x0 ^ x1 ^ scale_if_nonzero(x1, x0) ^ scale_if_nonzero(x1, x2)
             ^ scale_if_nonzero(x2, x0) ^ field_mul(s0, s1) ^ field_mul(s0, s2)
             ^ field_mul(s0, field_mul(x1, x2)) ^ field_mul(s2, field_mul(x0, x1));
  return r;
endfunction

function automatic logic [5:0] sbox_ref(logic [5:0] v);
  gf_pkg::gf64_t t;
  gf_pkg::gf64_t p;
  t.bits = apply_rows(fwd_rows, v);
  p = tower_power19(t);
  return apply_rows(inv_rows, p.bits) ^ {6{v[2] ^ v[4]}};
endfunction

function automatic logic [`SBOX_BLOCK-1:0] substitute_block(logic [`SBOX_BLOCK-1:0] d);
  logic [`SBOX_BLOCK-1:0] r;
  for (int k = 0; k < `SBOX_LANES; k++) begin
    r[k*`SBOX_WIDTH +: `SBOX_WIDTH] = sbox_ref(d[k*`SBOX_WIDTH +: `SBOX_WIDTH]);
  end
  return r;
endfunction

`endif

/* sim/tb_sbox_layer.sv */
`timescale 1ns/1ps
`include "sbox_cfg.svh"
module tb_sbox_layer;

  localparam int wait_limit = 64;

  logic                   clk;
  logic                   rst_n;
  logic                   in_valid;
  logic [`SBOX_BLOCK-1:0] in_data;
  logic                   out_valid;
  logic [`SBOX_BLOCK-1:0] out_data;

  logic [31:0]            rng_state;
  logic [`SBOX_BLOCK-1:0] exp_q [$]; // expected blocks in issue order.
  logic [`SBOX_BLOCK-1:0] obs_q [$];
  logic [5:0]             sbox_table [64];
  logic                   capture;
  int                     in_count;
  int                     out_count;
  int                     cyc;
  int                     last_in_cyc;
  int                     last_out_cyc;

  `include "sbox_model.svh"

  sbox_layer DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ****************************************
  // helpers
  // ****************************************

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [`SBOX_BLOCK-1:0] random_block();
    logic [31:0] r;
    r = next_random();
    return r[`SBOX_BLOCK-1:0];
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  task automatic drive_cycle(input logic valid, input logic [`SBOX_BLOCK-1:0] data);
    @(posedge clk);
    #1;
    in_valid = valid;
    in_data  = data;
    if (valid) begin
      exp_q.push_back(substitute_block(data));
    end
  endtask

  task automatic drain(input string name);
    int n;
    n = 0;
    drive_cycle(1'b0, random_block()); // lets the monitor count the last block.
    while (exp_q.size() != 0) begin
      if (n == wait_limit) begin
        abort_run({name, ": results stopped coming out of the pipeline"});
      end else begin
        drive_cycle(1'b0, random_block());
        n++;
      end
    end
    check({name, "_pulses"}, 32'(in_count), 32'(out_count));
  endtask

  task automatic check_lane_set(input int lane);
    int want [64];
    int seen [64];
    logic [5:0] o;
    for (int i = 0; i < 64; i++) begin
      want[i] = 0;
      seen[i] = 0;
    end
    for (int i = 0; i < 64; i++) begin
      want[sbox_table[i]]++;
    end
    check("sweep_size", 32'd64, 32'(obs_q.size()));
    foreach (obs_q[i]) begin
      o = obs_q[i][lane*`SBOX_WIDTH +: `SBOX_WIDTH];
      seen[o]++;
    end
    for (int i = 0; i < 64; i++) begin
      check("sweep_set", 32'(want[i]), 32'(seen[i]));
    end
  endtask

  // outputs are sampled on the falling edge, away from the drive time.
  always @(negedge clk) begin
    cyc++;
    if (in_valid === 1'b1) begin
      in_count++;
      last_in_cyc = cyc;
    end
    if (out_valid === 1'b1) begin
      out_count++;
      last_out_cyc = cyc;
      if (exp_q.size() == 0) begin
        abort_run("out_valid pulsed with no block in flight");
      end else begin
        check("out_data", 32'(exp_q.pop_front()), 32'(out_data));
        if (capture) obs_q.push_back(out_data);
      end
    end
  end

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    logic [`SBOX_BLOCK-1:0] blk;
    logic [31:0] gap;
    int base_in;
    int base_out;
    int n;
    rng_state = 32'd21;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    capture   = 1'b0;
    in_count  = 0;
    out_count = 0;
    cyc       = 0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    repeat (10) begin
      drive_cycle(1'b0, random_block());
      check("idle_valid", 32'd0, 32'(out_valid));
    end
    check("idle_count", 32'd0, 32'(out_count));

    for (int v = 0; v < 64; v++) begin
      sbox_table[v] = sbox_ref(6'(v));
    end
    for (int lane = 0; lane < `SBOX_LANES; lane++) begin
      obs_q.delete();
      capture = 1'b1;
      for (int v = 0; v < 64; v++) begin
        blk = random_block();
        blk[lane*`SBOX_WIDTH +: `SBOX_WIDTH] = 6'(v);
        drive_cycle(1'b1, blk);
      end
      drain("sweep");
      capture = 1'b0;
      check_lane_set(lane);
    end

    repeat (300) drive_cycle(1'b1, random_block());
    drain("random");

    base_out = out_count;
    drive_cycle(1'b1, random_block());
    drive_cycle(1'b0, random_block());
    n = 0;
    while (out_count == base_out) begin
      if (n == wait_limit) begin
        abort_run("latency: out_valid never rose for a single block");
      end else begin
        drive_cycle(1'b0, random_block());
        n++;
      end
    end
    check("latency", 32'd2, 32'(last_out_cyc - last_in_cyc));
    repeat (3) drive_cycle(1'b0, random_block());
    check("pulse_width", 32'(base_out + 1), 32'(out_count));

    base_in  = in_count;
    base_out = out_count;
    repeat (200) begin
      drive_cycle(1'b1, random_block());
      gap = next_random() % 4;
      repeat (gap) drive_cycle(1'b0, random_block());
    end
    drain("gapped");
    check("gap_blocks", 32'd200, 32'(in_count - base_in));
    check("gap_pulses", 32'(in_count - base_in), 32'(out_count - base_out));

    // both valid flops are set when reset is sampled, the first block at the output.
    drive_cycle(1'b1, random_block());
    drive_cycle(1'b1, random_block());
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    rst_n    = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    check("reset_flush", 32'd1, 32'(exp_q.size()));
    exp_q.delete();
    in_count--; // the second block never leaves the pipeline.
    base_out = out_count;
    repeat (10) begin
      drive_cycle(1'b0, random_block());
      check("reset_valid", 32'd0, 32'(out_valid));
    end
    check("reset_count", 32'(base_out), 32'(out_count));
    drive_cycle(1'b1, random_block());
    drain("after_reset");

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* src/sbox_layer.sv */
`timescale 1ns/1ps
`include "sbox_cfg.svh"
module sbox_layer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic [`SBOX_BLOCK-1:0] in_data,
  output logic                   out_valid,
  output logic [`SBOX_BLOCK-1:0] out_data
);

  // bit 0 tracks stage 1 and bit 1 tracks the output register.
  logic [1:0] valid_q;

  // ****************************************
  // valid pipeline
  // ****************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 2'b00;
    end else begin
      valid_q <= {valid_q[0], in_valid}; // one new block may enter every cycle.
    end
  end

  assign out_valid = valid_q[1];

  // ****************************************
  // substitution lanes
  // ****************************************

  // Lane k owns bits 6k+5:6k in both directions.
  for (genvar k = 0; k < `SBOX_LANES; k++) begin : g_lane
    sbox_core u_core (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_word  (in_data[k*`SBOX_WIDTH +: `SBOX_WIDTH]),
      .out_word (out_data[k*`SBOX_WIDTH +: `SBOX_WIDTH])
    );
  end

endmodule

/* src/sbox_core.sv */
`timescale 1ns/1ps
`include "sbox_cfg.svh"
module sbox_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic [`SBOX_WIDTH-1:0] in_word,
  output logic [`SBOX_WIDTH-1:0] out_word
);

  gf_pkg::gf64_t          fwd;   // input in the tower basis.
  gf_pkg::gf64_t          pw;    // 19th power, still in the tower basis.
  gf_pkg::gf64_t          pw_q;
  logic [`SBOX_WIDTH-1:0] raw_q; // raw input kept for the mask.
  logic                   s2_en;
  logic [`SBOX_WIDTH-1:0] inv;
  logic                   mask;

  // ****************************************
  // stage 1
  // ****************************************

  // polynomial basis to GF((2^2)^3).
  always_comb begin
    fwd.bits[0] = in_word[0] ^ in_word[1] ^ in_word[2] ^ in_word[5];
    fwd.bits[1] = in_word[1] ^ in_word[2] ^ in_word[3] ^ in_word[5];
    fwd.bits[2] = in_word[0] ^ in_word[2] ^ in_word[4] ^ in_word[5];
    fwd.bits[3] = in_word[1] ^ in_word[2] ^ in_word[4] ^ in_word[5];
    fwd.bits[4] = in_word[0] ^ in_word[5];
    fwd.bits[5] = in_word[4];
  end

  gf64_power19 u_pow (
    .a (fwd),
    .b (pw)
  );

  always_ff @(posedge clk) begin
    if (in_valid) begin
      pw_q  <= pw;
      raw_q <= in_word;
    end
  end

  // stage 2 loads only in the cycle after a word was taken in.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_en <= 1'b0;
    end else begin
      s2_en <= in_valid;
    end
  end

  // ****************************************
  // stage 2
  // ****************************************

  // tower basis back to the polynomial basis.
  always_comb begin
    inv[0] = pw_q.bits[0] ^ pw_q.bits[2] ^ pw_q.bits[5];
    inv[1] = pw_q.bits[4];
    inv[2] = pw_q.bits[1] ^ pw_q.bits[2];
    inv[3] = pw_q.bits[1] ^ pw_q.bits[2] ^ pw_q.bits[4] ^ pw_q.bits[5];
    inv[4] = pw_q.bits[0] ^ pw_q.bits[2];
    inv[5] = pw_q.bits[2] ^ pw_q.bits[3] ^ pw_q.bits[4] ^ pw_q.bits[5];
  end

  assign mask = raw_q[2] ^ raw_q[4]; // same mask bit goes onto every output bit.

  always_ff @(posedge clk) begin
    if (s2_en) begin
      out_word <= inv ^ {`SBOX_WIDTH{mask}};
    end
  end

endmodule

/* src/gf64_power19.sv */
`timescale 1ns/1ps
module gf64_power19 (
  input  gf_pkg::gf64_t a,
  output gf_pkg::gf64_t b
);

  gf_pkg::gf4_t x0;
  gf_pkg::gf4_t x1;
  gf_pkg::gf4_t x2;
  gf_pkg::gf4_t s0;
  gf_pkg::gf4_t s1;
  gf_pkg::gf4_t s2;
  gf_pkg::gf4_t cs01;
  gf_pkg::gf4_t cs02;
  gf_pkg::gf4_t cs10;
  gf_pkg::gf4_t cs12;
  gf_pkg::gf4_t cs20;
  gf_pkg::gf4_t cs21;
  gf_pkg::gf4_t sq01;
  gf_pkg::gf4_t sq02;
  gf_pkg::gf4_t sq12;
  gf_pkg::gf4_t m01;
  gf_pkg::gf4_t m02;
  gf_pkg::gf4_t m12;
  gf_pkg::gf4_t n0;
  gf_pkg::gf4_t n1;
  gf_pkg::gf4_t n2;
  gf_pkg::gf4_t d0;
  gf_pkg::gf4_t d1;
  gf_pkg::gf4_t d2;

  assign x0 = a.digit[0];
  assign x1 = a.digit[1];
  assign x2 = a.digit[2];

  assign s0 = gf_pkg::gf4_sq(x0);
  assign s1 = gf_pkg::gf4_sq(x1);
  assign s2 = gf_pkg::gf4_sq(x2);

  // ****************************************
  // product terms
  // ****************************************

  assign cs01 = gf_pkg::gf4_cube_scale(x0, x1);
  assign cs02 = gf_pkg::gf4_cube_scale(x0, x2);
  assign cs10 = gf_pkg::gf4_cube_scale(x1, x0);
  assign cs12 = gf_pkg::gf4_cube_scale(x1, x2);
  assign cs20 = gf_pkg::gf4_cube_scale(x2, x0);
  assign cs21 = gf_pkg::gf4_cube_scale(x2, x1);

  assign sq01 = gf_pkg::gf4_mul(s0, s1);
  assign sq02 = gf_pkg::gf4_mul(s0, s2);
  assign sq12 = gf_pkg::gf4_mul(s1, s2);

  assign m01 = gf_pkg::gf4_mul(x0, x1);
  assign m02 = gf_pkg::gf4_mul(x0, x2);
  assign m12 = gf_pkg::gf4_mul(x1, x2);

  // Each nested product pairs one square with the other two digits.
  assign n0 = gf_pkg::gf4_mul(s0, m12);
  assign n1 = gf_pkg::gf4_mul(s1, m02);
  assign n2 = gf_pkg::gf4_mul(s2, m01);

  // ****************************************
  // output adder chains
  // ****************************************

  always_comb begin
    // digit 0 sums x1 x2 cs01 cs20 cs21 sq01 sq12 n0 n1.
    d0 = gf_pkg::gf4_add(x1, x2);
    d0 = gf_pkg::gf4_add(d0, cs01);
    d0 = gf_pkg::gf4_add(d0, cs20);
    d0 = gf_pkg::gf4_add(d0, cs21);
    d0 = gf_pkg::gf4_add(d0, sq01);
    d0 = gf_pkg::gf4_add(d0, sq12);
    d0 = gf_pkg::gf4_add(d0, n0);
    d0 = gf_pkg::gf4_add(d0, n1);
  end

  always_comb begin
    // digit 1 sums x0 x2 cs01 cs02 cs12 sq02 sq12 n1 n2.
    d1 = gf_pkg::gf4_add(x0, x2);
    d1 = gf_pkg::gf4_add(d1, cs01);
    d1 = gf_pkg::gf4_add(d1, cs02);
    d1 = gf_pkg::gf4_add(d1, cs12);
    d1 = gf_pkg::gf4_add(d1, sq02);
    d1 = gf_pkg::gf4_add(d1, sq12);
    d1 = gf_pkg::gf4_add(d1, n1);
    d1 = gf_pkg::gf4_add(d1, n2);
  end

  always_comb begin
    // digit 2 sums x0 x1 cs10 cs12 cs20 sq01 sq02 n0 n2.
    d2 = gf_pkg::gf4_add(x0, x1);
    d2 = gf_pkg::gf4_add(d2, cs10);
    d2 = gf_pkg::gf4_add(d2, cs12);
    d2 = gf_pkg::gf4_add(d2, cs20);
    d2 = gf_pkg::gf4_add(d2, sq01);
    d2 = gf_pkg::gf4_add(d2, sq02);
    d2 = gf_pkg::gf4_add(d2, n0);
    d2 = gf_pkg::gf4_add(d2, n2);
  end

  assign b.digit[0] = d0;
  assign b.digit[1] = d1;
  assign b.digit[2] = d2;

endmodule

/* src/gf_pkg.sv */
package gf_pkg;

  // ****************************************
  // tower field types
  // ****************************************

  typedef logic [1:0] gf4_t; // bit 1 is the w part and w*w equals w+1.

  // a GF(2^6) word is three GF(4) digits with digit 0 in the low bits.
  typedef union packed {
    logic [5:0] bits;
    gf4_t [2:0] digit;
  } gf64_t;

  // ****************************************
  // GF(4) arithmetic
  // ****************************************

  function automatic gf4_t gf4_add(gf4_t a, gf4_t b);
    return a ^ b;
  endfunction

  function automatic gf4_t gf4_sq(gf4_t a);
    gf4_t r;
    r[0] = a[0] ^ a[1];
    r[1] = a[1]; // squaring is the Frobenius map.
    return r;
  endfunction

  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    logic t;
    gf4_t r;
    t    = a[1] & b[1]; // the w*w term folds back into both bits.
    r[0] = (a[0] & b[0]) ^ t;
    r[1] = (a[0] & b[1]) ^ (a[1] & b[0]) ^ t;
    return r;
  endfunction

  // every nonzero element of GF(4) has a cube of one.
  function automatic gf4_t gf4_cube_scale(gf4_t a, gf4_t b);
    logic nz;
    nz = a[0] | a[1];
    return nz ? b : 2'b00;
  endfunction

endpackage

/* src/sbox_cfg.svh */
`ifndef SBOX_CFG_SVH
`define SBOX_CFG_SVH

// One S-box word is a single GF(2^6) element.
`define SBOX_WIDTH 6

// number of S-boxes working side by side.
`define SBOX_LANES 4

`define SBOX_BLOCK (`SBOX_WIDTH * `SBOX_LANES) // full block seen by the layer.

`endif
